/* bench/axi_memory_model.sv */
`timescale 1ns/1ns

module axi_memory_model #(
    parameter sd_bus_pkg::data_t FILL_PATTERN = 32'h5A3C_96E1
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   ar_valid,
    input  sd_bus_pkg::addr_t      ar_addr,
    input  sd_bus_pkg::burst_len_t ar_len,
    input  logic                   r_ready,
    input  logic                   stall_ar,
    input  logic                   stall_r,
    output logic                   ar_ready,
    output logic                   r_valid,
    output logic                   r_last,
    output sd_bus_pkg::data_t      r_data
);
    import sd_bus_pkg::*;

    // Written words; everything else reads as a pattern of its address
    data_t words [addr_t];

    logic  in_burst;
    addr_t beat_addr;
    int    beats_left;
    logic  rst_seen;
    logic  hold_beat;
    logic  stall_a;
    logic  stall_d;

    task automatic write_word(input addr_t addr, input data_t value);
        words[addr] = value;
    endtask

    task automatic clear_words();
        words.delete();
    endtask

    function automatic data_t read_word(input addr_t addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return addr ^ FILL_PATTERN;
    endfunction

    initial begin
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r_last     = 1'b0;
        r_data     = '0;
        in_burst   = 1'b0;
        beat_addr  = '0;
        beats_left = 0;
    end

    always @(posedge clock) begin
        // Everything the model reacts to, as seen at the edge
        rst_seen  = reset;
        stall_a   = stall_ar;
        stall_d   = stall_r;
        hold_beat = r_valid && !r_ready;
        if (!rst_seen) begin
            in_burst = 1'b0;
        end else begin
            if (r_valid && r_ready) begin
                beat_addr  = beat_addr + addr_t'(WORD_BYTES);
                beats_left = beats_left - 1;
                in_burst   = (beats_left != 0);
            end
            if (ar_valid && ar_ready) begin
                in_burst   = 1'b1;
                beat_addr  = ar_addr;
                beats_left = int'(ar_len) + 1;
            end
        end
        #2;
        // One burst at a time, so the address is refused while data flows
        ar_ready = rst_seen && !in_burst && ar_valid && !stall_a;
        r_valid  = in_burst && (hold_beat || !stall_d);
        r_last   = in_burst && (beats_left == 1);
        r_data   = in_burst ? read_word(beat_addr) : '0;
    end

endmodule

/* bench/sd_dma_asserts.sv */
`timescale 1ns/1ns

module sd_dma_asserts #(
    parameter int BURST_BEATS = 16
) (
    input logic                   clock,
    input logic                   reset,
    input logic                   ar_valid,
    input logic                   ar_ready,
    input sd_bus_pkg::addr_t      ar_addr,
    input sd_bus_pkg::burst_len_t ar_len,
    input logic                   card_valid,
    input logic                   card_ready,
    input sd_bus_pkg::data_t      card_data
);
    import sd_bus_pkg::*;

    // Burst length capped at BURST_BEATS
    burst_cap: assert property (@(posedge clock) disable iff (!reset)
        ar_valid |-> ar_len <= burst_len_t'(BURST_BEATS - 1))
        else $error("ar_len %0d exceeds the burst cap", ar_len);

    // Address phase held until accepted
    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid && !ar_ready |=> $stable(ar_addr) && $stable(ar_len))
        else $error("ar_addr or ar_len changed while ar_valid waited");

    // Head word steady under card back-pressure
    card_hold: assert property (@(posedge clock) disable iff (!reset)
        card_valid && !card_ready |=> $stable(card_data))
        else $error("card_data changed while card_ready was low");

endmodule

/* bench/sd_dma_tb.sv */
`timescale 1ns/1ns

module sd_dma_tb;
    import sd_bus_pkg::*;
    import sd_adma_pkg::*;

    localparam int         BURST_BEATS  = 16;
    localparam int         FIFO_DEPTH   = 32;
    localparam int         NUM_ROWS     = 5;
    localparam int         WAIT_LIMIT   = 5000;
    localparam data_t      FILL_PATTERN = 32'h5A3C_96E1;
    localparam logic [1:0] DONE_ONLY    = 2'(1 << INT_XFER_DONE);
    localparam logic [1:0] ERR_ONLY     = 2'(1 << INT_ADMA_ERR);

    // Up to four descriptors, each stored at its own address
    typedef struct packed {
        addr_t            base;
        int               n_desc;
        addr_t [3:0]      desc_at;
        desc_line_t [3:0] desc;
        word_count_t      exp_words;
        logic [1:0]       exp_int;
        logic             stress;
    } scenario_t;

    logic       clock;
    logic       reset;
    logic       start;
    logic       int_clear;
    addr_t      descriptor_base;
    logic       ar_ready;
    logic       r_valid;
    logic       r_last;
    data_t      r_data;
    logic       card_ready;
    logic       busy;
    logic [1:0] dma_int;
    logic       ar_valid;
    logic       r_ready;
    addr_t      ar_addr;
    burst_len_t ar_len;
    logic       card_valid;
    data_t      card_data;
    logic       stall_ar;
    logic       stall_r;
    logic       stress;

    scenario_t   rows [NUM_ROWS];
    data_t       got_words [$];
    addr_t       got_bursts [$];
    burst_len_t  got_lens [$];
    data_t       exp_words [$];
    addr_t       exp_bursts [$];
    burst_len_t  exp_lens [$];
    logic [15:0] lfsr_state = 16'd38;
    int          mismatches = 0;
    int          failures = 0;
    int          rows_run = 0;
    logic        aborted = 1'b0;

    sd_dma_top #(
        .BURST_BEATS(BURST_BEATS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut0 (
        .clock(clock), .reset(reset), .start(start), .int_clear(int_clear),
        .descriptor_base(descriptor_base), .ar_ready(ar_ready), .r_valid(r_valid),
        .r_last(r_last), .r_data(r_data), .card_ready(card_ready), .busy(busy),
        .dma_int(dma_int), .ar_valid(ar_valid), .r_ready(r_ready), .ar_addr(ar_addr),
        .ar_len(ar_len), .card_valid(card_valid), .card_data(card_data)
    );

    axi_memory_model #(
        .FILL_PATTERN(FILL_PATTERN)
    ) mem0 (
        .clock(clock), .reset(reset), .ar_valid(ar_valid), .ar_addr(ar_addr),
        .ar_len(ar_len), .r_ready(r_ready), .stall_ar(stall_ar), .stall_r(stall_r),
        .ar_ready(ar_ready), .r_valid(r_valid), .r_last(r_last), .r_data(r_data)
    );

    bind sd_dma_top sd_dma_asserts #(.BURST_BEATS(BURST_BEATS)) asserts0 (
        .clock(clock), .reset(reset), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .ar_addr(ar_addr), .ar_len(ar_len), .card_valid(card_valid),
        .card_ready(card_ready), .card_data(card_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    //////////////////////////////
    // Random stalls and monitors
    //////////////////////////////

    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    always @(posedge clock) begin : drive_stalls
        logic       use_random;
        logic [4:0] bits;
        use_random = stress;
        #2;
        if (use_random) begin
            for (int i = 0; i < 5; i++) begin
                bits[i] = next_random_bit();
            end
            card_ready = !(bits[0] && bits[1]);
            stall_ar   = bits[2];
            stall_r    = bits[3] && bits[4];
        end else begin
            card_ready = 1'b1;
            stall_ar   = 1'b0;
            stall_r    = 1'b0;
        end
    end

    // Card-side sink and burst log
    always @(posedge clock) begin
        if (reset && card_valid && card_ready) begin
            got_words.push_back(card_data);
        end
        if (reset && ar_valid && ar_ready) begin
            got_bursts.push_back(ar_addr);
            got_lens.push_back(ar_len);
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic inspect_len(input string name, input burst_len_t got,
                               input burst_len_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic verify_count(input string name, input word_count_t got,
                                input word_count_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic expect_int(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic test_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    //////////////////////////////
    // Scenario table
    //////////////////////////////

    function automatic desc_line_t make_desc(input act_t act, input logic valid,
                                             input logic last, input int len_bytes,
                                             input addr_t addr);
        desc_line_t d;
        d = '0;
        d[DESC_VALID_BIT] = valid;
        d[DESC_END_BIT] = last;
        d[DESC_ACT_LSB +: 2] = act;
        d[DESC_LEN_LSB +: DESC_LEN_W] = len_bytes[15:0];
        d[DESC_ADDR_LSB +: ADDR_W] = addr;
        return d;
    endfunction

    task automatic new_row(input int r, input addr_t base, input int words,
                           input logic [1:0] ints, input logic stress_on);
        rows[r] = '0;
        rows[r].base = base;
        rows[r].exp_words = word_count_t'(words);
        rows[r].exp_int = ints;
        rows[r].stress = stress_on;
    endtask

    task automatic add_desc(input int r, input addr_t at, input desc_line_t line);
        rows[r].desc_at[rows[r].n_desc] = at;
        rows[r].desc[rows[r].n_desc] = line;
        rows[r].n_desc = rows[r].n_desc + 1;
    endtask

    task automatic load_rows();
        // Single 40-word tran with end
        new_row(0, 32'h0000_1000, 40, DONE_ONLY, 1'b0);
        add_desc(0, 32'h0000_1000, make_desc(act_tran, 1'b1, 1'b1, 160, 32'h0001_0000));
        // Nop, link to a second table, then tran with end
        new_row(1, 32'h0000_2000, 12, DONE_ONLY, 1'b0);
        add_desc(1, 32'h0000_2000, make_desc(act_nop, 1'b1, 1'b0, 0, '0));
        add_desc(1, 32'h0000_2008, make_desc(act_link, 1'b1, 1'b0, 0, 32'h0000_3000));
        add_desc(1, 32'h0000_3000, make_desc(act_tran, 1'b1, 1'b1, 48, 32'h0002_0000));
        // Tran, then a descriptor without the valid bit
        new_row(2, 32'h0000_4000, 16, ERR_ONLY, 1'b0);
        add_desc(2, 32'h0000_4000, make_desc(act_tran, 1'b1, 1'b0, 64, 32'h0003_0000));
        add_desc(2, 32'h0000_4008, make_desc(act_tran, 1'b0, 1'b1, 32, 32'h0003_8000));
        // Two trans under stalls and wait states
        new_row(3, 32'h0000_5000, 60, DONE_ONLY, 1'b1);
        add_desc(3, 32'h0000_5000, make_desc(act_tran, 1'b1, 1'b0, 100, 32'h0004_0000));
        add_desc(3, 32'h0000_5008, make_desc(act_tran, 1'b1, 1'b1, 140, 32'h0004_8000));
        // Zero-length tran moves nothing
        new_row(4, 32'h0000_6000, 5, DONE_ONLY, 1'b1);
        add_desc(4, 32'h0000_6000, make_desc(act_tran, 1'b1, 1'b0, 0, 32'h0005_0000));
        add_desc(4, 32'h0000_6008, make_desc(act_tran, 1'b1, 1'b1, 20, 32'h0005_0000));
    endtask

    // Walk the chain by the ADMA2 rules for fetch bursts, data bursts and card words
    task automatic build_expected(input scenario_t row);
        desc_line_t d;
        act_t       act;
        addr_t      addr;
        int         words;
        int         beats;
        exp_words.delete();
        exp_bursts.delete();
        exp_lens.delete();
        for (int i = 0; i < row.n_desc; i++) begin
            d = row.desc[i];
            act = act_t'(d[DESC_ACT_LSB +: 2]);
            addr = d[DESC_ADDR_LSB +: ADDR_W];
            words = int'(d[DESC_LEN_LSB +: DESC_LEN_W]) / WORD_BYTES;
            exp_bursts.push_back(row.desc_at[i]);
            exp_lens.push_back(burst_len_t'(DESC_WORDS - 1));
            if (!d[DESC_VALID_BIT]) begin
                break;
            end
            if (act == act_tran) begin
                for (int w = 0; w < words; w++) begin
                    if (w % BURST_BEATS == 0) begin
                        beats = (words - w < BURST_BEATS) ? words - w : BURST_BEATS;
                        exp_bursts.push_back(addr + addr_t'(w * WORD_BYTES));
                        exp_lens.push_back(burst_len_t'(beats - 1));
                    end
                    exp_words.push_back((addr + addr_t'(w * WORD_BYTES)) ^ FILL_PATTERN);
                end
            end
            if (d[DESC_END_BIT] && act != act_link) begin
                break;
            end
        end
    endtask

    //////////////////////////////
    // One scenario
    //////////////////////////////

    task automatic run_row(input int r);
        scenario_t row;
        int        cycles;
        row = rows[r];
        rows_run++;
        mem0.clear_words();
        for (int i = 0; i < row.n_desc; i++) begin
            mem0.write_word(row.desc_at[i], row.desc[i][31:0]);
            mem0.write_word(row.desc_at[i] + addr_t'(WORD_BYTES), row.desc[i][63:32]);
        end
        build_expected(row);
        stress = row.stress;
        int_clear = 1'b1;
        @(posedge clock);
        #2;
        int_clear = 1'b0;
        expect_int("dma_int after int_clear", dma_int, 2'b00);
        got_words.delete();
        got_bursts.delete();
        got_lens.delete();
        descriptor_base = row.base;
        start = 1'b1;
        @(posedge clock);
        #2;
        start = 1'b0;
        test_flag("busy after start", busy, 1'b1);

        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            #2;
            cycles++;
        end
        if (busy) begin
            failures++;
            $display("Timeout: busy still high after %0d cycles in scenario %0d", cycles, r);
            aborted = 1'b1;
            return;
        end
        expect_int("dma_int", dma_int, row.exp_int);

        // Drain what the card has not taken yet
        cycles = 0;
        while (card_valid && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            #2;
            cycles++;
        end
        if (card_valid) begin
            failures++;
            $display("Timeout: FIFO did not drain in scenario %0d", r);
            aborted = 1'b1;
            return;
        end
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            #2;
            test_flag("card_valid after drain", card_valid, 1'b0);
            test_flag("ar_valid after drain", ar_valid, 1'b0);
        end

        verify_count("card word count", word_count_t'(got_words.size()), row.exp_words);
        for (int i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
            check_data($sformatf("card_data[%0d]", i), got_words[i], exp_words[i]);
        end
        verify_count("burst count", word_count_t'(got_bursts.size()),
                     word_count_t'(exp_bursts.size()));
        for (int i = 0; i < exp_bursts.size() && i < got_bursts.size(); i++) begin
            compare_addr($sformatf("ar_addr[%0d]", i), got_bursts[i], exp_bursts[i]);
            inspect_len($sformatf("ar_len[%0d]", i), got_lens[i], exp_lens[i]);
        end
    endtask

    initial begin
        reset = 1'b0;
        start = 1'b0;
        int_clear = 1'b0;
        descriptor_base = '0;
        card_ready = 1'b1;
        stall_ar = 1'b0;
        stall_r = 1'b0;
        stress = 1'b0;
        load_rows();
        repeat (4) @(posedge clock);
        #2;
        test_flag("busy in reset", busy, 1'b0);
        test_flag("ar_valid in reset", ar_valid, 1'b0);
        test_flag("r_ready in reset", r_ready, 1'b0);
        test_flag("card_valid in reset", card_valid, 1'b0);
        expect_int("dma_int in reset", dma_int, 2'b00);
        reset = 1'b1;

        for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
            run_row(r);
        end

        $display("Done: %0d scenarios, %0d mismatches, %0d other failures",
                 rows_run, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module sd_dma_tb -f sim.f

status=0
./obj_dir/Vsd_dma_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished without failure"

/* sim.f */
src/sd_bus_pkg.sv
src/sd_adma_pkg.sv
src/adma_descriptor_engine.sv
src/axi_burst_reader.sv
src/data_stream_fifo.sv
src/sd_dma_top.sv
bench/axi_memory_model.sv
bench/sd_dma_asserts.sv
bench/sd_dma_tb.sv

/* src/adma_descriptor_engine.sv */
`timescale 1ns/1ns

module adma_descriptor_engine (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    int_clear,
    input  sd_bus_pkg::addr_t       descriptor_base,
    input  logic                    req_ready,
    input  logic                    req_done,
    input  logic                    desc_word_valid,
    input  sd_bus_pkg::data_t       desc_word,
    output logic                    req_valid,
    output logic                    req_descriptor,
    output logic                    busy,
    output sd_bus_pkg::addr_t       req_addr,
    output sd_bus_pkg::word_count_t req_words,
    output logic [1:0]              dma_int
);
    import sd_bus_pkg::*;
    import sd_adma_pkg::*;

    adma_state_t state;
    addr_t       pointer;
    desc_line_t  desc_line;

    // Decoded fields of the current descriptor
    logic        desc_valid;
    logic        desc_end;
    act_t        desc_act;
    word_count_t desc_words;
    addr_t       desc_addr;
    addr_t       seq_pointer;

    logic        fetch_go;
    addr_t       fetch_addr;
    logic        tran_go;
    logic        finish_desc;
    logic        stop_err;
    logic        stop_done;

    assign desc_valid  = desc_line[DESC_VALID_BIT];
    assign desc_end    = desc_line[DESC_END_BIT];
    assign desc_act    = act_t'(desc_line[DESC_ACT_LSB +: 2]);
    assign desc_words  = word_count_t'(desc_line[DESC_LEN_LSB +: DESC_LEN_W] / WORD_BYTES);
    assign desc_addr   = desc_line[DESC_ADDR_LSB +: ADDR_W];
    assign seq_pointer = pointer + addr_t'(DESC_BYTES);

    assign busy = (state != st_stop);

    //////////////////////////////
    // Descriptor decisions
    //////////////////////////////

    always_comb begin
        fetch_go    = 1'b0;
        fetch_addr  = seq_pointer;
        tran_go     = 1'b0;
        finish_desc = 1'b0;
        case (state)
            st_stop: begin
                fetch_go   = start;
                fetch_addr = descriptor_base;
            end
            st_cadr: begin
                if (desc_valid) begin
                    if (desc_act == act_link) begin
                        fetch_go   = 1'b1;
                        fetch_addr = desc_addr;
                    end else if (desc_act == act_tran && desc_words != '0) begin
                        tran_go = 1'b1;
                    end else begin
                        // Nop, reserved, or tran with nothing to move
                        finish_desc = 1'b1;
                    end
                end
            end
            st_tfr: finish_desc = req_done;
            default: finish_desc = 1'b0;
        endcase
        if (finish_desc && !desc_end) begin
            fetch_go = 1'b1;
        end
    end

    assign stop_err  = (state == st_cadr) && !desc_valid;
    assign stop_done = finish_desc && desc_end;

    //////////////////////////////
    // State, request, interrupts
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= st_stop;
            req_valid <= 1'b0;
            dma_int   <= '0;
        end else begin
            if (fetch_go || tran_go) begin
                req_valid <= 1'b1;
            end else if (req_ready) begin
                req_valid <= 1'b0;
            end

            if (fetch_go) begin
                state <= st_fds;
            end else if (tran_go) begin
                state <= st_tfr;
            end else if (state == st_fds && req_done) begin
                state <= st_cadr;
            end else if (stop_err || stop_done) begin
                state <= st_stop;
            end

            // A new event wins over a clear in the same cycle
            if (int_clear) begin
                dma_int <= '0;
            end
            if (stop_err) begin
                dma_int[INT_ADMA_ERR] <= 1'b1;
            end
            if (stop_done) begin
                dma_int[INT_XFER_DONE] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_go) begin
            pointer        <= fetch_addr;
            req_addr       <= fetch_addr;
            req_words      <= word_count_t'(DESC_WORDS);
            req_descriptor <= 1'b1;
        end else if (tran_go) begin
            req_addr       <= desc_addr;
            req_words      <= desc_words;
            req_descriptor <= 1'b0;
        end
        // Low word first, shifted down as the high word lands
        if (desc_word_valid) begin
            desc_line <= {desc_word, desc_line[DESC_ADDR_LSB +: DATA_W]};
        end
    end

endmodule

/* src/axi_burst_reader.sv */
`timescale 1ns/1ns

module axi_burst_reader #(
    parameter int BURST_BEATS = 16,
    parameter int FIFO_DEPTH  = 32
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                req_valid,
    input  logic                                req_descriptor,
    input  sd_bus_pkg::addr_t                   req_addr,
    input  sd_bus_pkg::word_count_t             req_words,
    input  logic [$clog2(FIFO_DEPTH + 1)-1:0]   free_count,
    input  logic                                ar_ready,
    input  logic                                r_valid,
    input  logic                                r_last,
    input  sd_bus_pkg::data_t                   r_data,
    output logic                                req_ready,
    output logic                                req_done,
    output logic                                desc_word_valid,
    output logic                                push,
    output sd_bus_pkg::data_t                   desc_word,
    output sd_bus_pkg::data_t                   push_data,
    output sd_bus_pkg::addr_t                   ar_addr,
    output sd_bus_pkg::burst_len_t              ar_len,
    output logic                                ar_valid,
    output logic                                r_ready
);
    import sd_bus_pkg::*;

    typedef enum logic [1:0] {
        rd_idle,
        rd_addr,
        rd_data
    } rd_state_t;

    rd_state_t   state;
    word_count_t words_left;
    addr_t       next_addr;
    logic        fetch_desc;
    word_count_t burst_beats;
    logic        space_ok;
    logic        issue;
    logic        beat;

    // Next burst, capped at BURST_BEATS
    assign burst_beats = (words_left > word_count_t'(BURST_BEATS)) ?
                         word_count_t'(BURST_BEATS) : words_left;

    // Previous burst has fully landed in the FIFO by the time this is checked
    assign space_ok = fetch_desc || (word_count_t'(free_count) >= burst_beats);
    assign issue    = (state == rd_addr) && !ar_valid && space_ok;

    assign req_ready = (state == rd_idle);
    assign r_ready   = (state == rd_data);
    assign beat      = r_valid && r_ready;

    // Beat routing
    assign desc_word_valid = beat && fetch_desc;
    assign desc_word       = r_data;
    assign push            = beat && !fetch_desc;
    assign push_data       = r_data;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state    <= rd_idle;
            ar_valid <= 1'b0;
            req_done <= 1'b0;
        end else begin
            req_done <= 1'b0;
            case (state)
                rd_idle: begin
                    if (req_valid) begin
                        if (req_words == '0) begin
                            req_done <= 1'b1;
                        end else begin
                            state <= rd_addr;
                        end
                    end
                end
                rd_addr: begin
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                        state    <= rd_data;
                    end else if (issue) begin
                        ar_valid <= 1'b1;
                    end
                end
                rd_data: begin
                    if (beat && r_last) begin
                        if (words_left == '0) begin
                            req_done <= 1'b1;
                            state    <= rd_idle;
                        end else begin
                            state <= rd_addr;
                        end
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            words_left <= req_words;
            next_addr  <= req_addr;
            fetch_desc <= req_descriptor;
        end
        if (issue) begin
            ar_addr <= next_addr;
            ar_len  <= burst_len_t'(burst_beats - 1'b1);
        end
        // Account for the burst once the address is taken
        if (ar_valid && ar_ready) begin
            words_left <= words_left - burst_beats;
            next_addr  <= next_addr + addr_t'(burst_beats) * addr_t'(WORD_BYTES);
        end
    end

endmodule

/* src/data_stream_fifo.sv */
`timescale 1ns/1ns

module data_stream_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                push,
    input  logic                                card_ready,
    input  sd_bus_pkg::data_t                   push_data,
    output logic                                card_valid,
    output logic [$clog2(FIFO_DEPTH + 1)-1:0]   free_count,
    output sd_bus_pkg::data_t                   card_data
);
    import sd_bus_pkg::*;

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

    data_t              mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               pop;

    // Wraps at FIFO_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign card_valid = (count != '0);
    assign card_data  = mem[rd_ptr];
    assign pop        = card_valid && card_ready;
    assign free_count = COUNT_W'(FIFO_DEPTH) - count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* src/sd_adma_pkg.sv */
// ADMA2 descriptor format and engine encodings

package sd_adma_pkg;

    //////////////////////////////
    // Descriptor line
    //////////////////////////////

    // Low word holds attributes and length, high word the address
    typedef logic [63:0] desc_line_t;

    // Attribute bits
    localparam int DESC_VALID_BIT = 0;
    localparam int DESC_END_BIT   = 1;

    // Act field position
    localparam int DESC_ACT_LSB = 4;

    // Length in bytes, bits 31:16
    localparam int DESC_LEN_LSB = 16;
    localparam int DESC_LEN_W   = 16;

    // Address word
    localparam int DESC_ADDR_LSB = 32;

    typedef enum logic [1:0] {
        act_nop  = 2'b00,
        act_rsv  = 2'b01,
        act_tran = 2'b10,
        act_link = 2'b11
    } act_t;

    // Pointer step past one descriptor, and its size in bus words
    localparam int DESC_BYTES = 8;
    localparam int DESC_WORDS = 2;

    //////////////////////////////
    // Engine
    //////////////////////////////

    typedef enum logic [1:0] {
        st_stop,
        st_fds,
        st_cadr,
        st_tfr
    } adma_state_t;

    // dma_int bit positions
    localparam int INT_XFER_DONE = 0;
    localparam int INT_ADMA_ERR  = 1;

endpackage

/* src/sd_bus_pkg.sv */
// System bus definitions shared by the DMA read path

package sd_bus_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Byte address on the system bus
    localparam int ADDR_W = 32;

    // One bus beat, also one FIFO entry
    localparam int DATA_W = 32;

    // Address step from one word to the next
    localparam int WORD_BYTES = DATA_W / 8;

    //////////////////////////////
    // Types
    //////////////////////////////

    // System-memory byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // Data word on the read channel and in the FIFO
    typedef logic [DATA_W-1:0] data_t;

    // AXI length field, beats minus one
    typedef logic [7:0] burst_len_t;

    // Words in one read request
    typedef logic [15:0] word_count_t;

endpackage

/* src/sd_dma_top.sv */
`timescale 1ns/1ns

module sd_dma_top #(
    parameter int BURST_BEATS = 16,
    parameter int FIFO_DEPTH  = 32
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    int_clear,
    input  sd_bus_pkg::addr_t       descriptor_base,
    input  logic                    ar_ready,
    input  logic                    r_valid,
    input  logic                    r_last,
    input  sd_bus_pkg::data_t       r_data,
    input  logic                    card_ready,
    output logic                    busy,
    output logic [1:0]              dma_int,
    output logic                    ar_valid,
    output logic                    r_ready,
    output sd_bus_pkg::addr_t       ar_addr,
    output sd_bus_pkg::burst_len_t  ar_len,
    output logic                    card_valid,
    output sd_bus_pkg::data_t       card_data
);
    import sd_bus_pkg::*;

    // Engine to reader
    logic        req_valid;
    logic        req_ready;
    logic        req_done;
    logic        req_descriptor;
    addr_t       req_addr;
    word_count_t req_words;
    logic        desc_word_valid;
    data_t       desc_word;

    // Reader to FIFO
    logic                              push;
    data_t                             push_data;
    logic [$clog2(FIFO_DEPTH + 1)-1:0] free_count;

    adma_descriptor_engine engine0 (
        .clock(clock), .reset(reset), .start(start), .int_clear(int_clear),
        .descriptor_base(descriptor_base),
        .req_ready(req_ready), .req_done(req_done),
        .desc_word_valid(desc_word_valid), .desc_word(desc_word),
        .req_valid(req_valid), .req_descriptor(req_descriptor), .busy(busy),
        .req_addr(req_addr), .req_words(req_words), .dma_int(dma_int)
    );

    axi_burst_reader #(
        .BURST_BEATS(BURST_BEATS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) reader0 (
        .clock(clock), .reset(reset),
        .req_valid(req_valid), .req_descriptor(req_descriptor),
        .req_addr(req_addr), .req_words(req_words), .free_count(free_count),
        .ar_ready(ar_ready), .r_valid(r_valid), .r_last(r_last), .r_data(r_data),
        .req_ready(req_ready), .req_done(req_done),
        .desc_word_valid(desc_word_valid), .push(push),
        .desc_word(desc_word), .push_data(push_data),
        .ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .r_ready(r_ready)
    );

    data_stream_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo0 (
        .clock(clock), .reset(reset), .push(push), .card_ready(card_ready),
        .push_data(push_data), .card_valid(card_valid),
        .free_count(free_count), .card_data(card_data)
    );

endmodule
